//--- hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	input  riscvPkg::aluOpT op,
	output logic [31:0]     result,
	output logic            zero
);

	logic signedLess;
	logic [4:0] shamt;

	assign signedLess = $signed(a) < $signed(b);

	// shift amount from the low five bits only
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			riscvPkg::ALU_ADD:
				result = a + b;
			riscvPkg::ALU_SUB:
				result = a - b;
			riscvPkg::ALU_AND:
				result = a & b;
			riscvPkg::ALU_OR:
				result = a | b;
			riscvPkg::ALU_XOR:
				result = a ^ b;
			riscvPkg::ALU_SLT:
				result = {31'd0, signedLess};
			riscvPkg::ALU_SLL:
				result = a << shamt;
			riscvPkg::ALU_SRL:
				result = a >> shamt;
			default:
				result = '0;
		endcase
	end

	// used by BEQ and BNE after a subtract
	assign zero = (result == 32'd0);

endmodule

//--- hw/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
	input  logic                 CLK,
	input  logic                 rstN,
	input  riscvPkg::instrWord   ir,
	input  logic                 aluZero,
	output riscvPkg::ctrlSignals ctrl,
	output logic                 halt,
	output logic [31:0]          numInst
);

	riscvPkg::cpuStateT state;
	riscvPkg::cpuStateT nextState;
	riscvPkg::opcodeT   opcode;
	logic               branchTaken;
	logic               retire;

	// funct3 to ALU operation, shared by R and I types
	function automatic riscvPkg::aluOpT decodeAluOp(input logic [2:0] funct3, input logic isSub);
		riscvPkg::aluOpT op;
		case (funct3)
			3'b000:  op = isSub ? riscvPkg::ALU_SUB : riscvPkg::ALU_ADD;
			3'b001:  op = riscvPkg::ALU_SLL;
			3'b010:  op = riscvPkg::ALU_SLT;
			3'b100:  op = riscvPkg::ALU_XOR;
			3'b101:  op = riscvPkg::ALU_SRL;
			3'b110:  op = riscvPkg::ALU_OR;
			3'b111:  op = riscvPkg::ALU_AND;
			default: op = riscvPkg::ALU_ADD;
		endcase
		return op;
	endfunction

	assign opcode = ir.r.opcode;

	// funct3 bit 0 separates BNE from BEQ
	assign branchTaken = ir.b.funct3[0] ? !aluZero : aluZero;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= riscvPkg::S_FETCH;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		ctrl = '0;
		case (state)
			riscvPkg::S_FETCH: begin
				ctrl.irWrite = 1'b1;
				ctrl.oldPcWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
				ctrl.aSel = riscvPkg::A_PC;
				ctrl.bSel = riscvPkg::B_FOUR;
				nextState = riscvPkg::S_DECODE;
			end
			riscvPkg::S_DECODE: begin
				// branch or jump target into ALUOut
				ctrl.aSel = riscvPkg::A_PC;
				ctrl.bSel = riscvPkg::B_IMM;
				ctrl.immSel = (opcode == riscvPkg::OPC_JAL) ? riscvPkg::IMM_J : riscvPkg::IMM_B;
				case (opcode)
					riscvPkg::OPC_OP, riscvPkg::OPC_OPIMM, riscvPkg::OPC_LOAD,
					riscvPkg::OPC_STORE, riscvPkg::OPC_BRANCH, riscvPkg::OPC_JAL:
						nextState = riscvPkg::S_EXEC;
					riscvPkg::OPC_SYSTEM:
						nextState = (ir == riscvPkg::EBREAK_WORD) ? riscvPkg::S_HALTED
							: riscvPkg::S_FETCH;
					default: nextState = riscvPkg::S_FETCH;
				endcase
			end
			riscvPkg::S_EXEC: begin
				ctrl.aSel = riscvPkg::A_REG;
				nextState = riscvPkg::S_FETCH;
				case (opcode)
					riscvPkg::OPC_OP: begin
						ctrl.bSel = riscvPkg::B_REG;
						ctrl.aluOp = decodeAluOp(ir.r.funct3, ir.r.funct7[5]);
						nextState = riscvPkg::S_WBALU;
					end
					riscvPkg::OPC_OPIMM: begin
						ctrl.bSel = riscvPkg::B_IMM;
						ctrl.immSel = riscvPkg::IMM_I;
						ctrl.aluOp = decodeAluOp(ir.i.funct3, 1'b0);
						nextState = riscvPkg::S_WBALU;
					end
					riscvPkg::OPC_LOAD: begin
						ctrl.bSel = riscvPkg::B_IMM;
						ctrl.immSel = riscvPkg::IMM_I;
						nextState = riscvPkg::S_MEMRD;
					end
					riscvPkg::OPC_STORE: begin
						ctrl.bSel = riscvPkg::B_IMM;
						ctrl.immSel = riscvPkg::IMM_S;
						nextState = riscvPkg::S_MEMWR;
					end
					riscvPkg::OPC_BRANCH: begin
						ctrl.bSel = riscvPkg::B_REG;
						ctrl.aluOp = riscvPkg::ALU_SUB;
						ctrl.pcWrite = branchTaken;
						ctrl.pcFromAluOut = 1'b1;
					end
					riscvPkg::OPC_JAL: begin
						// link value is the already incremented PC
						ctrl.regWrite = 1'b1;
						ctrl.wbFromPc = 1'b1;
						ctrl.pcWrite = 1'b1;
						ctrl.pcFromAluOut = 1'b1;
					end
					default: nextState = riscvPkg::S_FETCH;
				endcase
			end
			riscvPkg::S_MEMRD: begin
				ctrl.memRead = 1'b1;
				nextState = riscvPkg::S_WBMEM;
			end
			riscvPkg::S_MEMWR: begin
				ctrl.memWrite = 1'b1;
				nextState = riscvPkg::S_FETCH;
			end
			riscvPkg::S_WBALU: begin
				ctrl.regWrite = 1'b1;
				nextState = riscvPkg::S_FETCH;
			end
			riscvPkg::S_WBMEM: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbFromMem = 1'b1;
				nextState = riscvPkg::S_FETCH;
			end
			default: nextState = riscvPkg::S_HALTED;
		endcase
	end

	// last cycle of each instruction
	assign retire = (state == riscvPkg::S_WBALU) || (state == riscvPkg::S_WBMEM)
		|| (state == riscvPkg::S_MEMWR)
		|| ((state == riscvPkg::S_EXEC)
			&& ((opcode == riscvPkg::OPC_BRANCH) || (opcode == riscvPkg::OPC_JAL)));

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			numInst <= '0;
		end else if (retire) begin
			numInst <= numInst + 32'd1;
		end
	end

	assign halt = (state == riscvPkg::S_HALTED);

endmodule

//--- hw/immGen.sv
`timescale 1ns/1ps

module immGen (
	input  riscvPkg::instrWord ir,
	input  riscvPkg::immSelT   immSel,
	output logic [31:0]        imm
);

	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immJ;

	assign immI = {{20{ir.i.imm11to0[11]}}, ir.i.imm11to0};

	assign immS = {{20{ir.s.imm11to5[6]}}, ir.s.imm11to5, ir.s.imm4to0};

	// B and J offsets are in halfwords, low bit always zero
	assign immB = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11,
		ir.b.imm10to5, ir.b.imm4to1, 1'b0};

	assign immJ = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19to12,
		ir.j.imm11, ir.j.imm10to1, 1'b0};

	always_comb begin
		case (immSel)
			riscvPkg::IMM_I:
				imm = immI;
			riscvPkg::IMM_S:
				imm = immS;
			riscvPkg::IMM_B:
				imm = immB;
			riscvPkg::IMM_J:
				imm = immJ;
			default:
				imm = '0;
		endcase
	end

endmodule

//--- hw/riscvPkg.sv
package riscvPkg;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OPIMM  = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
	} aluOpT;

	typedef enum logic [2:0] {
		S_FETCH, S_DECODE, S_EXEC, S_MEMRD, S_MEMWR, S_WBALU, S_WBMEM, S_HALTED
	} cpuStateT;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J} immSelT;

	typedef enum logic {A_PC, A_REG} aSelT;

	typedef enum logic [1:0] {B_REG, B_IMM, B_FOUR} bSelT;

	// one 32-bit word, five ISA formats
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeT     opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm11to0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcodeT      opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] imm11to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4to0;
		opcodeT     opcode;
	} sTypeT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		opcodeT     opcode;
	} bTypeT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		opcodeT     opcode;
	} jTypeT;

	typedef union packed {
		rTypeT r;
		iTypeT i;
		sTypeT s;
		bTypeT b;
		jTypeT j;
	} instrWord;

	typedef struct packed {
		logic   pcWrite;
		logic   oldPcWrite;
		logic   irWrite;
		aSelT   aSel;
		bSelT   bSel;
		aluOpT  aluOp;
		immSelT immSel;
		logic   regWrite;
		logic   wbFromMem;
		logic   wbFromPc;
		logic   memRead;
		logic   memWrite;
		logic   pcFromAluOut;
	} ctrlSignals;

	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

endpackage

//--- hw/riscvTop.sv
`timescale 1ns/1ps

module riscvTop #(
	parameter int addrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 rstN,

	// instruction memory, byte address
	output logic                 iMemCsN,
	input  logic [31:0]          iMemData,
	output logic [addrWidth-1:0] iMemAddr,

	// data memory, byte address
	output logic                 dMemCsN,
	output logic                 dMemWeN,
	output logic [addrWidth-1:0] dMemAddr,
	output logic [31:0]          dMemWdata,
	input  logic [31:0]          dMemRdata,

	// register file
	output logic                 rfWe,
	output logic [4:0]           rfRa1,
	output logic [4:0]           rfRa2,
	output logic [4:0]           rfWa,
	input  logic [31:0]          rfRd1,
	input  logic [31:0]          rfRd2,
	output logic [31:0]          rfWd,

	output logic                 halt,
	output logic [31:0]          numInst,
	output logic [31:0]          outputPort
);

	riscvPkg::ctrlSignals ctrl;
	riscvPkg::instrWord   ir;

	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] oldPc;
	logic [addrWidth-1:0] instrPc;
	logic [addrWidth-1:0] pcNext;
	logic [31:0]          pcExt;
	logic [31:0]          instrPcExt;
	logic [31:0]          mdr;
	logic [31:0]          regA;
	logic [31:0]          regB;
	logic [31:0]          aluOut;
	logic [31:0]          imm;
	logic [31:0]          aluA;
	logic [31:0]          aluB;
	logic [31:0]          aluResult;
	logic                 aluZero;

	controlFsm fsm0 (
		.CLK     (CLK),
		.rstN    (rstN),
		.ir      (ir),
		.aluZero (aluZero),
		.ctrl    (ctrl),
		.halt    (halt),
		.numInst (numInst)
	);

	immGen imm0 (
		.ir     (ir),
		.immSel (ctrl.immSel),
		.imm    (imm)
	);

	aluUnit alu0 (
		.a      (aluA),
		.b      (aluB),
		.op     (ctrl.aluOp),
		.result (aluResult),
		.zero   (aluZero)
	);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (ctrl.pcWrite) begin
			pc <= pcNext;
		end
	end

	// address of the instruction in flight
	always_ff @(posedge CLK) begin
		if (ctrl.oldPcWrite) begin
			oldPc <= pc;
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.irWrite) begin
			ir <= iMemData;
		end
	end

	// operand, data and result latches load every cycle
	always_ff @(posedge CLK) begin
		regA <= rfRd1;
		regB <= rfRd2;
		mdr <= dMemRdata;
		aluOut <= aluResult;
	end

	assign pcNext = ctrl.pcFromAluOut ? aluOut[addrWidth-1:0] : aluResult[addrWidth-1:0];

	// oldPc is only valid once FETCH has passed
	assign instrPc = ctrl.irWrite ? pc : oldPc;
	assign instrPcExt = {{(32 - addrWidth){1'b0}}, instrPc};
	assign pcExt = {{(32 - addrWidth){1'b0}}, pc};

	assign aluA = (ctrl.aSel == riscvPkg::A_REG) ? regA : instrPcExt;

	always_comb begin
		case (ctrl.bSel)
			riscvPkg::B_REG:  aluB = regB;
			riscvPkg::B_IMM:  aluB = imm;
			riscvPkg::B_FOUR: aluB = 32'd4;
			default:          aluB = regB;
		endcase
	end

	// writeback source, pc already holds old pc plus four for JAL
	always_comb begin
		if (ctrl.wbFromPc) begin
			rfWd = pcExt;
		end else if (ctrl.wbFromMem) begin
			rfWd = mdr;
		end else begin
			rfWd = aluOut;
		end
	end

	assign iMemCsN = !ctrl.irWrite;
	assign iMemAddr = pc;

	assign dMemCsN = !(ctrl.memRead || ctrl.memWrite);
	assign dMemWeN = !ctrl.memWrite;
	assign dMemAddr = aluOut[addrWidth-1:0];
	assign dMemWdata = regB;

	assign rfWe = ctrl.regWrite;
	assign rfRa1 = ir.r.rs1;
	assign rfRa2 = ir.r.rs2;
	assign rfWa = ir.r.rd;

	assign outputPort = rfWd;

endmodule

//--- riscvTop.f
+incdir+testbench
hw/riscvPkg.sv
hw/aluUnit.sv
hw/immGen.sv
hw/controlFsm.sv
hw/riscvTop.sv
testbench/tbRiscv.sv

//--- runSim.sh
#!/bin/bash
# build and run the riscvTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --top-module tbRiscv -f riscvTop.f -o tbRiscv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tbRiscv > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$logFile"; then
	exit 1
fi
exit 0

//--- testbench/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference state of the ISA model
logic [31:0] refRegs [32];
logic [31:0] refMem [1024];
logic [31:0] expPc [$];
logic [31:0] expWa [$];
logic [31:0] expWd [$];
logic [31:0] expStAddr [$];
logic [31:0] expStData [$];
int          expCount;

function automatic logic [31:0] signExtI(input riscvPkg::instrWord w);
	return {{20{w.i.imm11to0[11]}}, w.i.imm11to0};
endfunction

function automatic logic [31:0] storeOffset(input riscvPkg::instrWord w);
	return {{20{w.s.imm11to5[6]}}, w.s.imm11to5, w.s.imm4to0};
endfunction

function automatic logic [31:0] branchOffset(input riscvPkg::instrWord w);
	return {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10to5, w.b.imm4to1, 1'b0};
endfunction

function automatic logic [31:0] jumpOffset(input riscvPkg::instrWord w);
	return {{11{w.j.imm20}}, w.j.imm20, w.j.imm19to12, w.j.imm11, w.j.imm10to1, 1'b0};
endfunction

// RV32I result for funct3, sub only matters for 000
function automatic logic [31:0] refAlu(input logic [2:0] funct3, input logic sub,
	input logic [31:0] a, input logic [31:0] b);
	case (funct3)
		3'b000:  return sub ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b100:  return a ^ b;
		3'b101:  return a >> b[4:0];
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

task automatic executeProgram();
	riscvPkg::instrWord w;
	logic [31:0] pc;
	logic [31:0] nextPc;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] addr;
	logic [31:0] res;
	logic        writesRd;
	logic        done;
	int          steps;
	expPc.delete();
	expWa.delete();
	expWd.delete();
	expStAddr.delete();
	expStData.delete();
	refRegs = initRegs;
	refMem = initMem;
	expCount = 0;
	pc = '0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 1024) begin
		w = iMem[pc[addrWidth-1:2]];
		expPc.push_back(pc);
		a = refRegs[w.r.rs1];
		b = refRegs[w.r.rs2];
		nextPc = pc + 32'd4;
		writesRd = 1'b0;
		res = '0;
		case (w.r.opcode)
			riscvPkg::OPC_OP: begin
				res = refAlu(w.r.funct3, w.r.funct7[5], a, b);
				writesRd = 1'b1;
			end
			riscvPkg::OPC_OPIMM: begin
				res = refAlu(w.i.funct3, 1'b0, a, signExtI(w));
				writesRd = 1'b1;
			end
			riscvPkg::OPC_LOAD: begin
				addr = a + signExtI(w);
				res = refMem[addr[addrWidth-1:2]];
				writesRd = 1'b1;
			end
			riscvPkg::OPC_STORE: begin
				addr = a + storeOffset(w);
				refMem[addr[addrWidth-1:2]] = b;
				expStAddr.push_back(32'(addr[addrWidth-1:0]));
				expStData.push_back(b);
			end
			riscvPkg::OPC_BRANCH: begin
				// funct3 000 is BEQ, 001 is BNE
				if (w.b.funct3[0] ? (a != b) : (a == b)) begin
					nextPc = pc + branchOffset(w);
				end
			end
			riscvPkg::OPC_JAL: begin
				res = pc + 32'd4;
				writesRd = 1'b1;
				nextPc = pc + jumpOffset(w);
			end
			default: done = 1'b1;
		endcase
		if (writesRd) begin
			expWa.push_back({27'd0, w.r.rd});
			expWd.push_back(res);
			if (w.r.rd != 5'd0) begin
				refRegs[w.r.rd] = res;
			end
		end
		if (!done) begin
			expCount++;
		end
		pc = nextPc;
		steps++;
	end
endtask

`endif

//--- testbench/tbRiscv.sv
`timescale 1ns/1ps

module tbRiscv;

	localparam int addrWidth = 12;
	localparam int clkPeriod = 4;
	localparam int resetCycles = 10;
	localparam int settleCycles = 20;
	localparam int numPrograms = 20;
	localparam int progLen = 64;
	// five cycles per instruction at worst and twice that
	localparam int timeoutNs = 2 * (numPrograms * progLen * 5 * clkPeriod
		+ numPrograms * (resetCycles + settleCycles) * clkPeriod);

	logic                 CLK;
	logic                 rstN;
	logic                 iMemCsN;
	logic [31:0]          iMemData;
	logic [addrWidth-1:0] iMemAddr;
	logic                 dMemCsN;
	logic                 dMemWeN;
	logic [addrWidth-1:0] dMemAddr;
	logic [31:0]          dMemWdata;
	logic [31:0]          dMemRdata;
	logic                 rfWe;
	logic [4:0]           rfRa1;
	logic [4:0]           rfRa2;
	logic [4:0]           rfWa;
	logic [31:0]          rfRd1;
	logic [31:0]          rfRd2;
	logic [31:0]          rfWd;
	logic                 halt;
	logic [31:0]          numInst;
	logic [31:0]          outputPort;

	logic [31:0] iMem [1024];
	logic [31:0] dMem [1024];
	logic [31:0] regs [32];
	logic [31:0] initMem [1024];
	logic [31:0] initRegs [32];
	integer      seed;
	int          errors;
	int          checks;
	logic        running;

	`include "tbModel.svh"

	riscvTop #(.addrWidth(addrWidth)) dut0 (
		.CLK        (CLK),
		.rstN       (rstN),
		.iMemCsN    (iMemCsN),
		.iMemData   (iMemData),
		.iMemAddr   (iMemAddr),
		.dMemCsN    (dMemCsN),
		.dMemWeN    (dMemWeN),
		.dMemAddr   (dMemAddr),
		.dMemWdata  (dMemWdata),
		.dMemRdata  (dMemRdata),
		.rfWe       (rfWe),
		.rfRa1      (rfRa1),
		.rfRa2      (rfRa2),
		.rfWa       (rfWa),
		.rfRd1      (rfRd1),
		.rfRd2      (rfRd2),
		.rfWd       (rfWd),
		.halt       (halt),
		.numInst    (numInst),
		.outputPort (outputPort)
	);

	assign iMemData = iMem[iMemAddr[addrWidth-1:2]];
	assign dMemRdata = dMem[dMemAddr[addrWidth-1:2]];
	assign rfRd1 = regs[rfRa1];
	assign rfRd2 = regs[rfRa2];

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	// memories reload their start state while reset is low
	always @(posedge CLK) begin
		if (!rstN) begin
			regs <= initRegs;
			dMem <= initMem;
		end else begin
			if (rfWe && rfWa != 5'd0) begin
				regs[rfWa] <= rfWd;
			end
			if (!dMemCsN && !dMemWeN) begin
				dMem[dMemAddr[addrWidth-1:2]] <= dMemWdata;
			end
		end
	end

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("[FAIL] %0t ns %s expected %08h actual %08h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic reportError(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		errors++;
	endtask

	// forward branches and jumps only with a final EBREAK
	task automatic buildProgram();
		logic [31:0] r;
		logic [31:0] f;
		logic [2:0]  f3;
		logic [4:0]  rs2;
		logic [11:0] off12;
		logic [20:0] off21;
		for (int i = 0; i < progLen - 1; i++) begin
			r = randWord();
			f = randWord();
			off12 = {2'b00, r[27:20], 2'b00};
			off21 = 21'((1 + r[31:16] % (progLen - 1 - i)) * 4);
			case (r[2:0])
				3'd0, 3'd1: begin
					// SLTU is outside the subset and becomes SLT
					f3 = (r[10:8] == 3'b011) ? 3'b010 : r[10:8];
					iMem[i] = {(f3 == 3'b000 && r[11]) ? 7'h20 : 7'h00, f[14:10], f[9:5], f3,
						f[4:0], riscvPkg::OPC_OP};
				end
				3'd2, 3'd3: begin
					case (r[10:8])
						3'd0, 3'd1: f3 = 3'b000;
						3'd2:       f3 = 3'b010;
						3'd3:       f3 = 3'b100;
						3'd4, 3'd5: f3 = 3'b110;
						default:    f3 = 3'b111;
					endcase
					iMem[i] = {r[31:20], f[9:5], f3, f[4:0], riscvPkg::OPC_OPIMM};
				end
				3'd4:
					iMem[i] = {off12, 5'd0, 3'b010, f[4:0], riscvPkg::OPC_LOAD};
				3'd5:
					iMem[i] = {off12[11:5], f[14:10], 5'd0, 3'b010, off12[4:0],
						riscvPkg::OPC_STORE};
				3'd6: begin
					// equal registers now and then so BEQ is taken
					rs2 = f[15] ? f[9:5] : f[14:10];
					iMem[i] = {off21[12], off21[10:5], rs2, f[9:5], 2'b00, r[12], off21[4:1],
						off21[11], riscvPkg::OPC_BRANCH};
				end
				default:
					iMem[i] = {off21[20], off21[10:1], off21[11], off21[19:12], f[4:0],
						riscvPkg::OPC_JAL};
			endcase
		end
		iMem[progLen-1] = riscvPkg::EBREAK_WORD;
	endtask

	task automatic randomizeState();
		initRegs[0] = '0;
		for (int i = 1; i < 32; i++) begin
			initRegs[i] = randWord();
		end
		for (int i = 0; i < 1024; i++) begin
			initMem[i] = randWord();
		end
	endtask

	always @(negedge CLK) begin : portMonitor
		logic [31:0] wantWd;
		if (running) begin
			if (!iMemCsN) begin
				if (expPc.size() == 0) begin
					reportError("instruction fetch past the end of the expected trace");
				end else begin
					check("iMemAddr", expPc.pop_front(), 32'(iMemAddr));
				end
			end
			if (rfWe) begin
				if (expWa.size() == 0) begin
					reportError("register write that the model does not expect");
				end else begin
					wantWd = expWd.pop_front();
					check("rfWa", expWa.pop_front(), {27'd0, rfWa});
					check("rfWd", wantWd, rfWd);
					check("outputPort", wantWd, outputPort);
				end
			end
			if (!dMemWeN) begin
				if (expStAddr.size() == 0) begin
					reportError("data memory store that the model does not expect");
				end else begin
					check("dMemAddr", expStAddr.pop_front(), 32'(dMemAddr));
					check("dMemWdata", expStData.pop_front(), dMemWdata);
				end
			end
		end
	end

	initial begin
		seed = 33774;
		errors = 0;
		checks = 0;
		rstN <= 1'b0;
		running <= 1'b0;
		for (int p = 0; p < numPrograms; p++) begin
			@(posedge CLK);
			rstN <= 1'b0;
			running <= 1'b0;
			buildProgram();
			randomizeState();
			executeProgram();
			repeat (resetCycles) @(posedge CLK);
			rstN <= 1'b1;
			running <= 1'b1;
			@(negedge CLK);
			check("halt", 32'd0, {31'd0, halt});
			check("numInst", 32'd0, numInst);
			check("iMemAddr", 32'd0, 32'(iMemAddr));
			check("dMemWeN", 32'd1, {31'd0, dMemWeN});
			check("dMemCsN", 32'd1, {31'd0, dMemCsN});
			while (!halt) @(negedge CLK);
			check("numInst", expCount, numInst);
			if (expPc.size() != 0 || expWa.size() != 0 || expStAddr.size() != 0) begin
				reportError($sformatf("program %0d halted with fetches, writes or stores missing",
					p));
			end
			for (int i = 0; i < 32; i++) begin
				check($sformatf("x%0d", i), refRegs[i], regs[i]);
			end
			for (int i = 0; i < 1024; i++) begin
				check($sformatf("dMem[%0d]", i), refMem[i], dMem[i]);
			end
			// halted core stays put
			repeat (settleCycles) begin
				@(negedge CLK);
				check("iMemCsN", 32'd1, {31'd0, iMemCsN});
				check("dMemCsN", 32'd1, {31'd0, dMemCsN});
				check("numInst", expCount, numInst);
			end
		end
		$display("%0d programs, %0d checks, %0d errors", numPrograms, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(timeoutNs);
		$display("the core did not halt, run stopped after %0d ns", timeoutNs);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
